//--- video_subsystem.f
logic/video_pkg.sv
logic/ahb_if.sv
logic/tft_timing.sv
logic/tft_dma.sv
logic/pixel_fifo.sv
logic/tft_pixel_out.sv
logic/pattern_slave.sv
logic/video_subsystem.sv
verification/video_subsystem_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = video_subsystem_tb
FILELIST  = video_subsystem.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the simulation prints the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/video_subsystem_tb.sv
`default_nettype none

module video_subsystem_tb;

    logic        clk_sys;
    logic        reset;
    logic        enable;
    logic        tft_dclk;
    logic        tft_disp;
    logic        tft_hsync_n;
    logic        tft_vsync_n;
    logic [23:0] tft_rgb;
    logic        underflow;

    // monitor state advanced on every clk_sys edge
    logic   started = 1'b0;
    logic   quiet_q = 1'b0;
    logic   en_q = 1'b0;
    logic   dclk_q = 1'b0;
    logic   hs_q = 1'b1;
    logic   vs_q = 1'b1;
    logic   h_armed = 1'b0;
    logic   v_armed = 1'b0;
    logic   synced = 1'b0;
    int     h_gap = 0;
    int     v_gap = 0;
    int     col = 0;
    int     line = 0;
    int     pix_checked = 0;
    int     vs_falls = 0;
    integer seed = 32'h2ba4de87;

    logic        dclk_rise;
    logic        hs_fall;
    logic        hs_rise;
    logic        vs_fall;
    logic        nxt_synced;
    logic        in_window;
    int          nxt_col;
    int          nxt_line;
    logic [7:0]  px;
    logic [7:0]  py;
    logic [23:0] exp_rgb;

    video_subsystem DUT (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .enable      (enable),
        .tft_dclk    (tft_dclk),
        .tft_disp    (tft_disp),
        .tft_hsync_n (tft_hsync_n),
        .tft_vsync_n (tft_vsync_n),
        .tft_rgb     (tft_rgb),
        .underflow   (underflow)
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    task automatic mismatch(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("ERR t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic wait_vsync_falls(input int count);
        int target;
        int limit;
        int n;
        @(negedge clk_sys);
        target = vs_falls + count;
        limit  = count * video_pkg::V_TOTAL * video_pkg::H_TOTAL * video_pkg::PCLK_DIV + 2000;
        n      = 0;
        while (vs_falls < target && n < limit) begin
            @(negedge clk_sys);
            n++;
        end
        if (vs_falls < target)
            timed_out($sformatf("%0d falls of tft_vsync_n", count));
    endtask

    // ------------------------------------------------------------------
    // reference model of the panel scan
    // ------------------------------------------------------------------
    assign dclk_rise = tft_dclk && !dclk_q;
    assign hs_fall   = hs_q && !tft_hsync_n;
    assign hs_rise   = !hs_q && tft_hsync_n;
    assign vs_fall   = vs_q && !tft_vsync_n;

    always_comb begin
        nxt_col = tft_hsync_n ? col + 1 : 0;
        if (tft_hsync_n)
            nxt_line = line;
        else if (tft_vsync_n)
            nxt_line = line + 1;
        else
            nxt_line = 0;
        nxt_synced = synced || (!tft_hsync_n && !tft_vsync_n);
        in_window  = nxt_col >= 3 && nxt_col <= 18 && nxt_line >= 2 && nxt_line <= 9;
        px         = 8'(nxt_col - 3);
        py         = 8'(nxt_line - 2);
        // red = x, green = y, blue = (x xor y) * 16
        exp_rgb    = in_window ? {px, py, 8'((px ^ py) * 16)} : 24'h0;
    end

    always_ff @(posedge clk_sys) begin
        started <= 1'b1;
        quiet_q <= reset || !enable;
        en_q    <= !reset && enable;
        dclk_q  <= tft_dclk;
        hs_q    <= tft_hsync_n;
        vs_q    <= tft_vsync_n;
        h_gap   <= hs_fall ? 1 : h_gap + 1;
        v_gap   <= vs_fall ? 1 : v_gap + 1;
        if (vs_fall)
            vs_falls <= vs_falls + 1;
        if (reset || !enable) begin
            h_armed <= 1'b0;
            v_armed <= 1'b0;
            synced  <= 1'b0;
            col     <= 0;
            line    <= 0;
        end else begin
            if (hs_fall)
                h_armed <= 1'b1;
            if (vs_fall)
                v_armed <= 1'b1;
            if (dclk_rise) begin
                col    <= nxt_col;
                line   <= nxt_line;
                synced <= nxt_synced;
                if (nxt_synced && in_window)
                    pix_checked <= pix_checked + 1;
            end
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    // panel parked during reset and while disabled
    park_hs: assert property (@(posedge clk_sys) quiet_q |-> tft_hsync_n == 1'b1)
        else mismatch("tft_hsync_n", 1, $sampled(tft_hsync_n));
    park_vs: assert property (@(posedge clk_sys) quiet_q |-> tft_vsync_n == 1'b1)
        else mismatch("tft_vsync_n", 1, $sampled(tft_vsync_n));
    park_dclk: assert property (@(posedge clk_sys) quiet_q |-> tft_dclk == 1'b0)
        else mismatch("tft_dclk", 0, $sampled(tft_dclk));
    park_rgb: assert property (@(posedge clk_sys) quiet_q |-> tft_rgb == 24'h0)
        else mismatch("tft_rgb", 0, $sampled(tft_rgb));

    disp_follows: assert property (@(posedge clk_sys) started |-> tft_disp == en_q)
        else mismatch("tft_disp", $sampled(en_q), $sampled(tft_disp));
    no_underflow: assert property (@(posedge clk_sys) started |-> underflow == 1'b0)
        else mismatch("underflow", 0, $sampled(underflow));

    // 22 pixel periods of 4 cycles per line, 11 lines per frame
    line_period: assert property (@(posedge clk_sys) (h_armed && hs_fall) |-> h_gap == 88)
        else mismatch("tft_hsync_n period", 88, $sampled(h_gap));
    hsync_width: assert property (@(posedge clk_sys) (h_armed && hs_rise) |-> h_gap == 4)
        else mismatch("tft_hsync_n low width", 4, $sampled(h_gap));
    frame_period: assert property (@(posedge clk_sys) (v_armed && vs_fall) |-> v_gap == 968)
        else mismatch("tft_vsync_n period", 968, $sampled(v_gap));

    pixel_value: assert property (@(posedge clk_sys) (dclk_rise && nxt_synced) |->
                                  tft_rgb == exp_rgb)
        else mismatch("tft_rgb", $sampled(exp_rgb), $sampled(tft_rgb));

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin
        int delay;
        int first_run;
        int restart_base;
        reset  = 1'b1;
        enable = 1'b0;
        repeat (10) @(posedge clk_sys);
        reset <= 1'b0;
        repeat (20) @(posedge clk_sys);
        enable <= 1'b1;

        // first frame syncs the model and three more are compared in full
        wait_vsync_falls(4);
        first_run = pix_checked;

        // drop enable somewhere inside a frame
        wait_vsync_falls(1);
        delay = 100 + ($unsigned($random(seed)) % 700);
        repeat (delay) @(posedge clk_sys);
        enable <= 1'b0;
        repeat (40) @(posedge clk_sys);
        restart_base = pix_checked;
        enable <= 1'b1;
        wait_vsync_falls(2);

        if (first_run < 3 * 128 || pix_checked - restart_base < 128) begin
            $display("too few pixels compared: %0d before, %0d after restart",
                     first_run, pix_checked - restart_base);
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- logic/video_subsystem.sv
`default_nettype none

module video_subsystem (
    input  logic                          clk_sys,
    input  logic                          reset,
    input  logic                          enable,
    output logic                          tft_dclk,
    output logic                          tft_disp,
    output logic                          tft_hsync_n,
    output logic                          tft_vsync_n,
    output logic [video_pkg::PIXEL_W-1:0] tft_rgb,
    output logic                          underflow
);

    // ----------------------------------------------------------------------
    // internal wiring
    // ----------------------------------------------------------------------
    logic                        pix_tick;
    logic                        dclk;
    logic                        hsync_n;
    logic                        vsync_n;
    logic                        active;
    logic                        frame_start;
    logic                        push;
    logic [31:0]                 push_data;
    logic                        pop;
    logic [31:0]                 pop_data;
    logic                        empty;
    logic [video_pkg::FIFO_AW:0] free;

    ahb_if bus ();

    tft_timing timing (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .enable      (enable),
        .pix_tick    (pix_tick),
        .dclk        (dclk),
        .hsync_n     (hsync_n),
        .vsync_n     (vsync_n),
        .active      (active),
        .frame_start (frame_start)
    );

    tft_dma dma (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .enable      (enable),
        .frame_start (frame_start),
        .bus         (bus.master),
        .push        (push),
        .push_data   (push_data),
        .free        (free)
    );

    // emptied while the panel is disabled
    pixel_fifo fifo (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .flush     (~enable),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty),
        .free      (free)
    );

    tft_pixel_out pix_out (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .enable      (enable),
        .pix_tick    (pix_tick),
        .dclk        (dclk),
        .hsync_n     (hsync_n),
        .vsync_n     (vsync_n),
        .active      (active),
        .pop         (pop),
        .pop_data    (pop_data),
        .empty       (empty),
        .tft_dclk    (tft_dclk),
        .tft_disp    (tft_disp),
        .tft_hsync_n (tft_hsync_n),
        .tft_vsync_n (tft_vsync_n),
        .tft_rgb     (tft_rgb),
        .underflow   (underflow)
    );

    // stands in for the frame buffer
    pattern_slave ptn (
        .clk_sys (clk_sys),
        .reset   (reset),
        .bus     (bus.slave)
    );

endmodule

`default_nettype wire

//--- logic/pattern_slave.sv
`default_nettype none

module pattern_slave (
    input  logic clk_sys,
    input  logic reset,
    ahb_if.slave bus
);

    logic [1:0]                    beat_cnt;
    logic                          dp_valid;
    logic                          dp_wait;
    logic [video_pkg::HADDR_W-1:0] dp_addr;
    logic [video_pkg::HADDR_W-1:0] offset;
    logic [video_pkg::HADDR_W-3:0] word_idx;
    logic [7:0]                    red;
    logic [7:0]                    green;
    logic [7:0]                    blue;
    logic                          accept;

    assign accept = bus.hready && !bus.hwrite &&
                    (bus.htrans == video_pkg::NONSEQ || bus.htrans == video_pkg::SEQ);

    // every third accepted beat is stretched by one cycle
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            beat_cnt <= '0;
            dp_valid <= 1'b0;
            dp_wait  <= 1'b0;
        end else if (bus.hready) begin
            dp_valid <= accept;
            dp_wait  <= accept && (beat_cnt == 2'd2);
            if (accept)
                beat_cnt <= (beat_cnt == 2'd2) ? 2'd0 : beat_cnt + 1'b1;
        end else begin
            dp_wait <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept)
            dp_addr <= bus.haddr;
    end

    // pattern from the word index of the captured address
    assign offset   = dp_addr - video_pkg::FB_BASE;
    assign word_idx = offset[video_pkg::HADDR_W-1:2];
    assign red      = 8'(word_idx % video_pkg::H_DISP);
    assign green    = 8'(word_idx / video_pkg::H_DISP);
    assign blue     = (red ^ green) * 8'd16;

    assign bus.hready = !(dp_valid && dp_wait);
    assign bus.hrdata = dp_valid ? 32'({red, green, blue}) : '0;
    assign bus.hresp  = 1'b0;

endmodule

`default_nettype wire

//--- logic/tft_pixel_out.sv
`default_nettype none

module tft_pixel_out (
    input  logic                          clk_sys,
    input  logic                          reset,
    input  logic                          enable,
    input  logic                          pix_tick,
    input  logic                          dclk,
    input  logic                          hsync_n,
    input  logic                          vsync_n,
    input  logic                          active,
    output logic                          pop,
    input  logic [31:0]                   pop_data,
    input  logic                          empty,
    output logic                          tft_dclk,
    output logic                          tft_disp,
    output logic                          tft_hsync_n,
    output logic                          tft_vsync_n,
    output logic [video_pkg::PIXEL_W-1:0] tft_rgb,
    output logic                          underflow
);

    // dclk already falls on the edge where the outputs below are registered
    assign tft_dclk = dclk;

    assign pop = pix_tick && active && !empty;

    always_ff @(posedge clk_sys) begin
        if (reset || !enable) begin
            tft_hsync_n <= 1'b1;
            tft_vsync_n <= 1'b1;
            tft_rgb     <= '0;
            underflow   <= 1'b0;
        end else if (pix_tick) begin
            tft_hsync_n <= hsync_n;
            tft_vsync_n <= vsync_n;
            if (pop)
                tft_rgb <= pop_data[video_pkg::PIXEL_W-1:0];
            else
                tft_rgb <= '0;
            // sticky until the panel is disabled
            if (active && empty)
                underflow <= 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset)
            tft_disp <= 1'b0;
        else
            tft_disp <= enable;
    end

endmodule

`default_nettype wire

//--- logic/pixel_fifo.sv
`default_nettype none

module pixel_fifo (
    input  logic                        clk_sys,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        push,
    input  logic [31:0]                 push_data,
    input  logic                        pop,
    output logic [31:0]                 pop_data,
    output logic                        empty,
    output logic [video_pkg::FIFO_AW:0] free
);

    logic [31:0]                    mem [video_pkg::FIFO_DEPTH];
    logic [video_pkg::FIFO_AW-1:0]  wr_ptr;
    logic [video_pkg::FIFO_AW-1:0]  rd_ptr;
    logic [video_pkg::FIFO_AW:0]    count;
    logic                           do_push;
    logic                           do_pop;

    assign empty    = count == '0;
    assign free     = (video_pkg::FIFO_AW + 1)'(video_pkg::FIFO_DEPTH) - count;
    assign pop_data = mem[rd_ptr];

    // pushes into a full FIFO are dropped
    assign do_push = push && (free != '0);
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk_sys) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

endmodule

`default_nettype wire

//--- logic/tft_dma.sv
`default_nettype none

module tft_dma (
    input  logic                        clk_sys,
    input  logic                        reset,
    input  logic                        enable,
    input  logic                        frame_start,
    ahb_if.master                       bus,
    output logic                        push,
    output logic [31:0]                 push_data,
    input  logic [video_pkg::FIFO_AW:0] free
);

    video_pkg::dma_state_t                    state;
    logic [video_pkg::HADDR_W-1:0]            addr;
    logic [$clog2(video_pkg::BURST_LEN)-1:0]  beat_cnt;
    logic [$clog2(video_pkg::FRAME_WORDS):0]  word_cnt;
    logic                                     data_pending;
    logic                                     addr_done;
    logic                                     room_ok;

    assign bus.haddr  = addr;
    assign bus.hburst = video_pkg::INCR8;
    assign bus.hwrite = 1'b0;

    always_comb begin
        bus.htrans = video_pkg::IDLE;
        if (state == video_pkg::DMA_ADDR) begin
            if (beat_cnt == '0)
                bus.htrans = video_pkg::NONSEQ;
            else
                bus.htrans = video_pkg::SEQ;
        end
    end

    // address phase of a beat completes here
    assign addr_done = (state == video_pkg::DMA_ADDR) && bus.hready;

    // one data phase at most is outstanding behind the address phase
    assign push      = data_pending && bus.hready && !bus.hresp;
    assign push_data = bus.hrdata;

    // room for a whole burst besides the beat still on its way
    assign room_ok = int'(free) >= video_pkg::BURST_LEN + int'(data_pending);

    always_ff @(posedge clk_sys) begin
        if (reset || !enable) begin
            state        <= video_pkg::DMA_IDLE;
            addr         <= video_pkg::FB_BASE;
            beat_cnt     <= '0;
            word_cnt     <= '0;
            data_pending <= 1'b0;
        end else begin
            if (bus.hready)
                data_pending <= addr_done;

            if (addr_done) begin
                addr     <= addr + 32'd4;
                beat_cnt <= beat_cnt + 1'b1;
                word_cnt <= word_cnt + 1'b1;
            end

            case (state)
                video_pkg::DMA_IDLE: begin
                    if (frame_start) begin
                        addr     <= video_pkg::FB_BASE;
                        word_cnt <= '0;
                        state    <= video_pkg::DMA_WAIT_ROOM;
                    end
                end
                video_pkg::DMA_WAIT_ROOM: begin
                    if (room_ok)
                        state <= video_pkg::DMA_ADDR;
                end
                video_pkg::DMA_ADDR: begin
                    if (bus.hready && int'(beat_cnt) == video_pkg::BURST_LEN - 1)
                        state <= video_pkg::DMA_DATA;
                end
                video_pkg::DMA_DATA: begin
                    // last beat of the burst returns
                    if (bus.hready) begin
                        if (int'(word_cnt) == video_pkg::FRAME_WORDS) begin
                            addr     <= video_pkg::FB_BASE;
                            word_cnt <= '0;
                            state    <= video_pkg::DMA_IDLE;
                        end else begin
                            state <= video_pkg::DMA_WAIT_ROOM;
                        end
                    end
                end
                default: state <= video_pkg::DMA_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/tft_timing.sv
`default_nettype none

module tft_timing (
    input  logic clk_sys,
    input  logic reset,
    input  logic enable,
    output logic pix_tick,
    output logic dclk,
    output logic hsync_n,
    output logic vsync_n,
    output logic active,
    output logic frame_start
);

    logic [$clog2(video_pkg::PCLK_DIV)-1:0] div_cnt;
    logic [$clog2(video_pkg::H_TOTAL)-1:0]  h_cnt;
    logic [$clog2(video_pkg::V_TOTAL)-1:0]  v_cnt;
    logic                                   h_active;
    logic                                   v_active;

    // last sub-cycle of a pixel period, dclk falls on this edge
    assign pix_tick = enable && (int'(div_cnt) == video_pkg::PCLK_DIV - 1);
    assign dclk     = int'(div_cnt) >= video_pkg::PCLK_DIV / 2;

    always_ff @(posedge clk_sys) begin
        if (reset || !enable) begin
            div_cnt <= '0;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else if (pix_tick) begin
            div_cnt <= '0;
            if (int'(h_cnt) == video_pkg::H_TOTAL - 1) begin
                h_cnt <= '0;
                if (int'(v_cnt) == video_pkg::V_TOTAL - 1)
                    v_cnt <= '0;
                else
                    v_cnt <= v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // decode of the current column and line
    // ----------------------------------------------------------------------
    assign hsync_n = !(int'(h_cnt) < video_pkg::H_SYNC);
    assign vsync_n = !(int'(v_cnt) < video_pkg::V_SYNC);

    assign h_active = (int'(h_cnt) >= video_pkg::H_SYNC + video_pkg::H_BACK) &&
                      (int'(h_cnt) < video_pkg::H_SYNC + video_pkg::H_BACK + video_pkg::H_DISP);
    assign v_active = (int'(v_cnt) >= video_pkg::V_SYNC + video_pkg::V_BACK) &&
                      (int'(v_cnt) < video_pkg::V_SYNC + video_pkg::V_BACK + video_pkg::V_DISP);
    assign active   = h_active && v_active;

    assign frame_start = pix_tick && (h_cnt == '0) && (v_cnt == '0);

endmodule

`default_nettype wire

//--- logic/ahb_if.sv
`default_nettype none

// read-only AHB-Lite, single master
interface ahb_if;

    logic [video_pkg::HADDR_W-1:0] haddr;
    video_pkg::htrans_t            htrans;
    video_pkg::hburst_t            hburst;
    logic                          hwrite;
    logic [31:0]                   hrdata;
    logic                          hready;
    logic                          hresp;

    modport master (
        output haddr, htrans, hburst, hwrite,
        input  hrdata, hready, hresp
    );

    modport slave (
        input  haddr, htrans, hburst, hwrite,
        output hrdata, hready, hresp
    );

endinterface

`default_nettype wire

//--- logic/video_pkg.sv
`default_nettype none

package video_pkg;

    // ----------------------------------------------------------------------
    // panel timing, horizontal in pixel periods, vertical in lines
    // ----------------------------------------------------------------------
    localparam int H_SYNC  = 1;
    localparam int H_BACK  = 2;
    localparam int H_DISP  = 16;
    localparam int H_FRONT = 3;
    localparam int H_TOTAL = H_SYNC + H_BACK + H_DISP + H_FRONT;

    localparam int V_SYNC  = 1;
    localparam int V_BACK  = 1;
    localparam int V_DISP  = 8;
    localparam int V_FRONT = 1;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_DISP + V_FRONT;

    // clk_sys cycles per pixel period
    localparam int PCLK_DIV = 4;

    // ----------------------------------------------------------------------
    // frame buffer, FIFO and widths
    // ----------------------------------------------------------------------
    localparam logic [31:0] FB_BASE = 32'h0f000000;
    localparam int FRAME_WORDS = H_DISP * V_DISP;
    localparam int BURST_LEN   = 8;

    localparam int FIFO_DEPTH = 32;
    localparam int FIFO_AW    = 5;

    localparam int PIXEL_W = 24;
    localparam int HADDR_W = 32;

    // AHB-Lite encodings
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        INCR8  = 3'b101
    } hburst_t;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_ADDR,
        DMA_DATA,
        DMA_WAIT_ROOM
    } dma_state_t;

endpackage

`default_nettype wire
